//--- common/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;
    typedef logic        a_sel_t;
    typedef logic [1:0]  b_sel_t;

    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLT    = 4'd5;
    localparam alu_op_t ALU_SLTU   = 4'd6;
    localparam alu_op_t ALU_SLL    = 4'd7;
    localparam alu_op_t ALU_SRL    = 4'd8;
    localparam alu_op_t ALU_SRA    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10; // lui

    localparam fwd_sel_t FWD_NONE = 2'd0;
    localparam fwd_sel_t FWD_MEM  = 2'd1;
    localparam fwd_sel_t FWD_WB   = 2'd2;

    localparam a_sel_t A_REG = 1'b0;
    localparam a_sel_t A_PC  = 1'b1;

    localparam b_sel_t B_REG  = 2'd0;
    localparam b_sel_t B_IMM  = 2'd1;
    localparam b_sel_t B_FOUR = 2'd2; // Link value for jal

    localparam inst_t INST_NOP = 32'h0000_0013; // addi x0, x0, 0

    function automatic word_t imm_i(inst_t inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic word_t imm_u(inst_t inst);
        return {inst[31:12], 12'b0};
    endfunction

    function automatic word_t imm_b(inst_t inst);
        return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic word_t imm_j(inst_t inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    // True for every supported opcode that writes rd
    function automatic logic writes_rd(inst_t inst);
        opcode_t op;
        op = inst[6:0];
        return op == OP_REG || op == OP_IMM || op == OP_LUI || op == OP_AUIPC || op == OP_JAL;
    endfunction

endpackage

//--- decode/id_stage.sv
module id_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              ex_flush,
    input  rv_pkg::word_t     if_pc,
    input  rv_pkg::inst_t     if_inst,
    input  logic              if_valid,
    input  logic              if_br_taken,
    input  logic              wb_valid,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data,
    output rv_pkg::word_t     id_pc,
    output rv_pkg::word_t     id_rd1,
    output rv_pkg::word_t     id_rd2,
    output rv_pkg::word_t     id_imm,
    output rv_pkg::inst_t     id_inst,
    output logic              id_valid,
    output logic              id_br_taken
);

    rv_pkg::word_t regs [1:31]; // x0 is not stored
    rv_pkg::word_t rd1;
    rv_pkg::word_t rd2;
    rv_pkg::word_t imm;

    // Read with bypass of the write happening this cycle
    function automatic rv_pkg::word_t rf_read(rv_pkg::reg_addr_t ra);
        if (ra == '0)
            return '0;
        if (wb_valid && wb_rd == ra)
            return wb_data;
        return regs[ra];
    endfunction

    always_ff @(posedge clk) begin
        if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rd1 = rf_read(if_inst[19:15]);
    assign rd2 = rf_read(if_inst[24:20]);

    always_comb begin
        case (rv_pkg::opcode_t'(if_inst[6:0]))
            rv_pkg::OP_IMM:    imm = rv_pkg::imm_i(if_inst);
            rv_pkg::OP_LUI,
            rv_pkg::OP_AUIPC:  imm = rv_pkg::imm_u(if_inst);
            rv_pkg::OP_BRANCH: imm = rv_pkg::imm_b(if_inst);
            rv_pkg::OP_JAL:    imm = rv_pkg::imm_j(if_inst);
            default:           imm = '0; // R-type has no immediate
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_inst     <= rv_pkg::INST_NOP;
            id_valid    <= 1'b0;
            id_br_taken <= 1'b0;
        end else if (ex_flush) begin
            // Wrong-path instruction becomes a bubble
            id_inst     <= rv_pkg::INST_NOP;
            id_valid    <= 1'b0;
            id_br_taken <= 1'b0;
        end else begin
            id_inst     <= if_inst;
            id_valid    <= if_valid;
            id_br_taken <= if_br_taken;
        end
    end

    always_ff @(posedge clk) begin
        id_pc  <= if_pc;
        id_rd1 <= rd1;
        id_rd2 <= rd2;
        id_imm <= imm;
    end

endmodule

//--- ex/ex_control.sv
module ex_control (
    input  rv_pkg::inst_t    id_inst,
    input  logic             id_valid,
    input  logic             id_br_taken,
    input  rv_pkg::inst_t    mem_inst,
    input  logic             mem_valid,
    input  rv_pkg::inst_t    wb_inst,
    input  logic             wb_valid,
    input  logic             breq,
    input  logic             brlt,
    output logic             brun,
    output rv_pkg::fwd_sel_t fwda,
    output rv_pkg::fwd_sel_t fwdb,
    output rv_pkg::a_sel_t   asel,
    output rv_pkg::b_sel_t   bsel,
    output rv_pkg::alu_op_t  alusel,
    output logic             br_taken_actual,
    output logic             br_suc,
    output logic             br_mispred,
    output logic             flush
);

    rv_pkg::opcode_t opcode;
    rv_pkg::funct3_t funct3;
    logic            is_branch;
    logic            is_jal;
    logic            cond;

    assign opcode    = id_inst[6:0];
    assign funct3    = id_inst[14:12];
    assign is_branch = id_valid && opcode == rv_pkg::OP_BRANCH;
    assign is_jal    = id_valid && opcode == rv_pkg::OP_JAL;

    // Younger producer wins; x0 never forwards
    function automatic rv_pkg::fwd_sel_t fwd_pick(rv_pkg::reg_addr_t rs);
        if (rs == '0)
            return rv_pkg::FWD_NONE;
        if (mem_valid && rv_pkg::writes_rd(mem_inst) && mem_inst[11:7] == rs)
            return rv_pkg::FWD_MEM;
        if (wb_valid && wb_inst[11:7] == rs)
            return rv_pkg::FWD_WB;
        return rv_pkg::FWD_NONE;
    endfunction

    assign fwda = fwd_pick(id_inst[19:15]);
    assign fwdb = fwd_pick(id_inst[24:20]);

    // funct7 bit 30 picks sub only for R-type, sra for both
    function automatic rv_pkg::alu_op_t arith_op(logic is_reg);
        case (funct3)
            3'b000:  return (is_reg && id_inst[30]) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return id_inst[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        asel   = rv_pkg::A_REG;
        bsel   = rv_pkg::B_REG;
        alusel = rv_pkg::ALU_ADD;
        case (opcode)
            rv_pkg::OP_REG: alusel = arith_op(1'b1);
            rv_pkg::OP_IMM: begin
                bsel   = rv_pkg::B_IMM;
                alusel = arith_op(1'b0);
            end
            rv_pkg::OP_LUI: begin
                bsel   = rv_pkg::B_IMM;
                alusel = rv_pkg::ALU_PASS_B;
            end
            rv_pkg::OP_AUIPC: begin
                asel = rv_pkg::A_PC;
                bsel = rv_pkg::B_IMM;
            end
            rv_pkg::OP_JAL: begin
                asel = rv_pkg::A_PC; // Link value pc+4
                bsel = rv_pkg::B_FOUR;
            end
            default: ;
        endcase
    end

    assign brun = (funct3 == rv_pkg::F3_BLTU) || (funct3 == rv_pkg::F3_BGEU);

    always_comb begin
        case (funct3)
            rv_pkg::F3_BEQ:  cond = breq;
            rv_pkg::F3_BNE:  cond = !breq;
            rv_pkg::F3_BLT,
            rv_pkg::F3_BLTU: cond = brlt;
            rv_pkg::F3_BGE,
            rv_pkg::F3_BGEU: cond = !brlt;
            default:         cond = 1'b0;
        endcase
    end

    assign br_taken_actual = is_branch ? cond : is_jal;
    assign br_suc          = is_branch && (cond == id_br_taken);
    assign br_mispred      = is_branch && (cond != id_br_taken);
    assign flush = (is_branch || is_jal) && (br_taken_actual != id_br_taken);

endmodule

//--- ex/ex_stage.sv
module ex_stage (
    input  logic          clk,
    input  logic          arst_n,
    input  rv_pkg::word_t id_pc,
    input  rv_pkg::word_t id_rd1,
    input  rv_pkg::word_t id_rd2,
    input  rv_pkg::word_t id_imm,
    input  rv_pkg::inst_t id_inst,
    input  logic          id_valid,
    input  logic          id_br_taken, // Prediction made in fetch
    input  rv_pkg::word_t mem_alu,     // Result one stage ahead
    input  rv_pkg::inst_t mem_inst,
    input  logic          mem_valid,
    input  rv_pkg::word_t wb_wdata,    // Result two stages ahead
    input  rv_pkg::inst_t wb_inst,
    input  logic          wb_valid,
    output logic          ex_flush,
    output rv_pkg::word_t ex_redirect_pc,
    output logic          ex_br_suc,
    output logic          ex_br_mispred,
    output rv_pkg::word_t ex_pc,
    output rv_pkg::word_t ex_alu,
    output rv_pkg::inst_t ex_inst,
    output logic          ex_valid
);

    rv_pkg::fwd_sel_t fwda;
    rv_pkg::fwd_sel_t fwdb;
    rv_pkg::a_sel_t   asel;
    rv_pkg::b_sel_t   bsel;
    rv_pkg::alu_op_t  alusel;
    rv_pkg::word_t    fwd_a;
    rv_pkg::word_t    fwd_b;
    rv_pkg::word_t    a;
    rv_pkg::word_t    b;
    rv_pkg::word_t    alu_res;
    rv_pkg::word_t    br_target;
    logic             brun;
    logic             breq;
    logic             brlt;
    logic             br_taken_actual;
    logic             br_suc;
    logic             br_mispred;

    function automatic rv_pkg::word_t fwd_mux(rv_pkg::fwd_sel_t sel, rv_pkg::word_t rf_val);
        case (sel)
            rv_pkg::FWD_MEM: return mem_alu;
            rv_pkg::FWD_WB:  return wb_wdata;
            default:         return rf_val;
        endcase
    endfunction

    assign fwd_a = fwd_mux(fwda, id_rd1);
    assign fwd_b = fwd_mux(fwdb, id_rd2);

    assign a = (asel == rv_pkg::A_PC) ? id_pc : fwd_a;

    always_comb begin
        case (bsel)
            rv_pkg::B_IMM:  b = id_imm;
            rv_pkg::B_FOUR: b = 32'd4;
            default:        b = fwd_b;
        endcase
    end

    // Branch compare on forwarded operands
    assign breq = (fwd_a == fwd_b);
    assign brlt = brun ? (fwd_a < fwd_b) : ($signed(fwd_a) < $signed(fwd_b));

    assign br_target      = id_pc + id_imm;
    assign ex_redirect_pc = br_taken_actual ? br_target : id_pc + 32'd4;

    alu alu (
        .a   (a),
        .b   (b),
        .sel (alusel),
        .res (alu_res)
    );

    ex_control control (
        .id_inst         (id_inst),
        .id_valid        (id_valid),
        .id_br_taken     (id_br_taken),
        .mem_inst        (mem_inst),
        .mem_valid       (mem_valid),
        .wb_inst         (wb_inst),
        .wb_valid        (wb_valid),
        .breq            (breq),
        .brlt            (brlt),
        .brun            (brun),
        .fwda            (fwda),
        .fwdb            (fwdb),
        .asel            (asel),
        .bsel            (bsel),
        .alusel          (alusel),
        .br_taken_actual (br_taken_actual),
        .br_suc          (br_suc),
        .br_mispred      (br_mispred),
        .flush           (ex_flush)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_inst       <= rv_pkg::INST_NOP;
            ex_valid      <= 1'b0;
            ex_br_suc     <= 1'b0;
            ex_br_mispred <= 1'b0;
        end else begin
            ex_inst       <= id_inst;
            ex_valid      <= id_valid;
            ex_br_suc     <= br_suc;     // One-cycle pulses
            ex_br_mispred <= br_mispred;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc  <= id_pc;
        ex_alu <= alu_res;
    end

endmodule

//--- fetch/fetch_stage.sv
module fetch_stage #(
    parameter rv_pkg::word_t RESET_PC = 32'h0
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          ex_flush,
    input  rv_pkg::word_t ex_redirect_pc,
    input  rv_pkg::inst_t imem_rdata,
    output rv_pkg::word_t imem_addr,
    output rv_pkg::word_t if_pc,
    output rv_pkg::inst_t if_inst,
    output logic          if_valid,
    output logic          if_br_taken
);

    rv_pkg::word_t   pc;
    rv_pkg::word_t   next_pc;
    rv_pkg::word_t   pred_target;
    rv_pkg::opcode_t opcode;
    logic            pred_taken;

    assign imem_addr = pc;
    assign opcode    = imem_rdata[6:0];

    // Predict jal always and conditional branches only when backward
    assign pred_taken = (opcode == rv_pkg::OP_JAL) ||
                        (opcode == rv_pkg::OP_BRANCH && imem_rdata[31]);
    assign pred_target = pc + ((opcode == rv_pkg::OP_JAL) ? rv_pkg::imm_j(imem_rdata)
                                                          : rv_pkg::imm_b(imem_rdata));
    assign next_pc = pred_taken ? pred_target : pc + 32'd4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc          <= RESET_PC;
            if_inst     <= rv_pkg::INST_NOP;
            if_valid    <= 1'b0;
            if_br_taken <= 1'b0;
        end else if (ex_flush) begin
            pc          <= ex_redirect_pc; // Resume on the corrected path
            if_inst     <= rv_pkg::INST_NOP;
            if_valid    <= 1'b0;
            if_br_taken <= 1'b0;
        end else begin
            pc          <= next_pc;
            if_inst     <= imem_rdata;
            if_valid    <= 1'b1;
            if_br_taken <= pred_taken;
        end
    end

    always_ff @(posedge clk) begin
        if_pc <= pc;
    end

endmodule

//--- src/alu.sv
module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_t sel,
    output rv_pkg::word_t   res
);

    always_comb begin
        case (sel)
            rv_pkg::ALU_ADD:    res = a + b;
            rv_pkg::ALU_SUB:    res = a - b;
            rv_pkg::ALU_AND:    res = a & b;
            rv_pkg::ALU_OR:     res = a | b;
            rv_pkg::ALU_XOR:    res = a ^ b;
            rv_pkg::ALU_SLT:    res = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU:   res = {31'b0, a < b};
            rv_pkg::ALU_SLL:    res = a << b[4:0]; // Shift amount is 5 bits
            rv_pkg::ALU_SRL:    res = a >> b[4:0];
            rv_pkg::ALU_SRA:    res = $signed(a) >>> b[4:0];
            rv_pkg::ALU_PASS_B: res = b;
            default:            res = '0;
        endcase
    end

endmodule

//--- src/cpu_top.sv
module cpu_top #(
    parameter rv_pkg::word_t RESET_PC = 32'h0
) (
    input  logic              clk,
    input  logic              arst_n,
    output rv_pkg::word_t     imem_addr,
    input  rv_pkg::inst_t     imem_rdata, // Same-cycle instruction memory
    output logic              wb_valid,
    output rv_pkg::word_t     wb_pc,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::word_t     wb_data,
    output logic              ex_br_suc,
    output logic              ex_br_mispred
);

    rv_pkg::word_t if_pc;
    rv_pkg::inst_t if_inst;
    logic          if_valid;
    logic          if_br_taken;

    rv_pkg::word_t id_pc;
    rv_pkg::word_t id_rd1;
    rv_pkg::word_t id_rd2;
    rv_pkg::word_t id_imm;
    rv_pkg::inst_t id_inst;
    logic          id_valid;
    logic          id_br_taken;

    rv_pkg::word_t ex_pc;
    rv_pkg::word_t ex_alu;
    rv_pkg::inst_t ex_inst;
    logic          ex_valid;
    logic          ex_flush;
    rv_pkg::word_t ex_redirect_pc;

    rv_pkg::inst_t wb_inst;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) fetch (.*);

    id_stage decode (.*);

    // EX/MEM and MEM/WB outputs feed the forwarding paths
    ex_stage execute (
        .mem_alu   (ex_alu),
        .mem_inst  (ex_inst),
        .mem_valid (ex_valid),
        .wb_wdata  (wb_data),
        .*
    );

    retire_stage retire (.*);

endmodule

//--- src/retire_stage.sv
module retire_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::word_t     ex_pc,
    input  rv_pkg::word_t     ex_alu,
    input  rv_pkg::inst_t     ex_inst,
    input  logic              ex_valid,
    output logic              wb_valid,
    output rv_pkg::word_t     wb_pc,
    output rv_pkg::reg_addr_t wb_rd,
    output rv_pkg::word_t     wb_data,
    output rv_pkg::inst_t     wb_inst
);

    logic we;

    // Branches and x0 targets retire silently
    assign we = ex_valid && rv_pkg::writes_rd(ex_inst) && ex_inst[11:7] != '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            wb_inst  <= rv_pkg::INST_NOP;
        end else begin
            wb_valid <= we;
            wb_inst  <= ex_inst;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc   <= ex_pc;
        wb_rd   <= ex_inst[11:7];
        wb_data <= ex_alu;
    end

endmodule

//--- tb.f
common/rv_pkg.sv
src/alu.sv
ex/ex_control.sv
ex/ex_stage.sv
fetch/fetch_stage.sv
decode/id_stage.sv
src/retire_stage.sv
src/cpu_top.sv
tests/ex_asserts.sv
tests/wb_checker.sv
tests/tb_top.sv

//--- tests/ex_asserts.sv
module ex_asserts (
    input logic          clk,
    input logic          arst_n,
    input logic          ex_flush,
    input logic          id_valid,
    input rv_pkg::inst_t id_inst,
    input logic          ex_valid,
    input logic          ex_br_suc,
    input logic          ex_br_mispred
);

    int fail_count = 0;

    // Only a resolved conditional branch may redirect fetch
    a_flush_is_branch: assert property (@(posedge clk) disable iff (!arst_n)
        ex_flush |-> id_valid && id_inst[6:0] == rv_pkg::OP_BRANCH)
        else begin
            fail_count++;
            $error("flush raised without a valid branch in execute");
        end

    a_pulses_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(ex_br_suc && ex_br_mispred))
        else begin
            fail_count++;
            $error("branch success and mispredict pulses high together");
        end

    // Valid bits and pulses stay low while reset is held
    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |=> !id_valid && !ex_valid && !ex_br_suc && !ex_br_mispred)
        else begin
            fail_count++;
            $error("valid bit or branch pulse high during reset");
        end

endmodule

bind ex_stage ex_asserts asserts (.*);

//--- tests/tb_top.sv
module tb_top;

    localparam rv_pkg::word_t RESET_PC = 32'h0;
    localparam int TIMEOUT = 2000;
    localparam rv_pkg::inst_t HALT = 32'h0000_006f; // jal x0, 0

    logic              clk;
    logic              arst_n;
    rv_pkg::word_t     imem_addr;
    rv_pkg::inst_t     imem_rdata;
    logic              wb_valid;
    rv_pkg::word_t     wb_pc;
    rv_pkg::reg_addr_t wb_rd;
    rv_pkg::word_t     wb_data;
    logic              ex_br_suc;
    logic              ex_br_mispred;

    rv_pkg::inst_t     imem [256];
    rv_pkg::inst_t     prog [$];
    rv_pkg::word_t     exp_pc [$];
    rv_pkg::reg_addr_t exp_rd [$];
    rv_pkg::word_t     exp_data [$];
    int                exp_suc;
    int                exp_mis;
    rv_pkg::word_t     halt_pc;
    int                tests_run = 0;
    int                tests_failed = 0;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    assign imem_rdata = imem[imem_addr[9:2]]; // Same-cycle read

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .imem_addr     (imem_addr),
        .imem_rdata    (imem_rdata),
        .wb_valid      (wb_valid),
        .wb_pc         (wb_pc),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .ex_br_suc     (ex_br_suc),
        .ex_br_mispred (ex_br_mispred)
    );

    wb_checker chk (
        .clk        (clk),
        .arst_n     (arst_n),
        .wb_valid   (wb_valid),
        .wb_pc      (wb_pc),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .br_suc     (ex_br_suc),
        .br_mispred (ex_br_mispred)
    );

    // Checker mismatches plus bound assertion failures
    function automatic int total_errors();
        return chk.errors + dut.execute.asserts.fail_count;
    endfunction

    function automatic rv_pkg::inst_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                            int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_pkg::OP_REG};
    endfunction

    function automatic rv_pkg::inst_t enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd);
        return {imm, 5'(rs1), f3, 5'(rd), rv_pkg::OP_IMM};
    endfunction

    function automatic rv_pkg::inst_t enc_u(logic [6:0] op, logic [19:0] imm, int rd);
        return {imm, 5'(rd), op};
    endfunction

    function automatic rv_pkg::inst_t enc_b(logic [12:0] imm, int rs2, int rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
    endfunction

    function automatic rv_pkg::inst_t enc_j(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), rv_pkg::OP_JAL};
    endfunction

    // RV32I arithmetic by funct3 with alt selecting sub or sra
    function automatic rv_pkg::word_t ref_alu(logic [2:0] f3, logic alt, rv_pkg::word_t a,
                                              rv_pkg::word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA model of the loaded program
    function automatic void rv_model();
        rv_pkg::word_t x [32];
        rv_pkg::word_t pc;
        rv_pkg::word_t res;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::inst_t in;
        logic          taken;
        logic          wr;
        foreach (x[i])
            x[i] = '0;
        exp_pc.delete();
        exp_rd.delete();
        exp_data.delete();
        exp_suc = 0;
        exp_mis = 0;
        pc = RESET_PC;
        for (int step = 0; step < 1000; step++) begin
            in = imem[pc[9:2]];
            if (in == HALT) begin
                halt_pc = pc;
                return;
            end
            a   = x[in[19:15]];
            b   = x[in[24:20]];
            wr  = 1'b1;
            res = '0;
            case (in[6:0])
                rv_pkg::OP_REG:   res = ref_alu(in[14:12], in[30], a, b);
                rv_pkg::OP_IMM:   res = ref_alu(in[14:12], in[14:12] == 3'd5 && in[30], a,
                                                {{20{in[31]}}, in[31:20]});
                rv_pkg::OP_LUI:   res = {in[31:12], 12'b0};
                rv_pkg::OP_AUIPC: res = pc + {in[31:12], 12'b0};
                rv_pkg::OP_JAL:   res = pc + 4;
                default:          wr = 1'b0;
            endcase
            if (in[6:0] == rv_pkg::OP_BRANCH) begin
                case (in[14:12])
                    rv_pkg::F3_BEQ:  taken = a == b;
                    rv_pkg::F3_BNE:  taken = a != b;
                    rv_pkg::F3_BLT:  taken = $signed(a) < $signed(b);
                    rv_pkg::F3_BGE:  taken = $signed(a) >= $signed(b);
                    rv_pkg::F3_BLTU: taken = a < b;
                    default:         taken = a >= b;
                endcase
                if (taken == in[31]) // Backward branches predicted taken
                    exp_suc++;
                else
                    exp_mis++;
            end
            if (wr && in[11:7] != 5'd0) begin
                x[in[11:7]] = res;
                exp_pc.push_back(pc);
                exp_rd.push_back(in[11:7]);
                exp_data.push_back(res);
            end
            if (in[6:0] == rv_pkg::OP_JAL)
                pc = pc + {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
            else if (in[6:0] == rv_pkg::OP_BRANCH && taken)
                pc = pc + {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
            else
                pc = pc + 4;
        end
        halt_pc = pc;
    endfunction

    task automatic load_and_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        for (int i = 0; i < 256; i++)
            imem[i] = enc_i(12'(i), 0, 3'd0, 0); // addi x0, x0, index
        foreach (prog[i])
            imem[i] = prog[i];
        rv_model();
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic run_test(int num, string name);
        int cycles;
        int errs_before;
        errs_before = total_errors();
        load_and_reset();
        cycles = 0;
        while (!(exp_pc.size() == 0 && wb_pc == halt_pc && chk.suc_cnt >= exp_suc &&
                 chk.mis_cnt >= exp_mis) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT) begin
            $display("Test %0d did not reach its final instruction within %0d cycles", num,
                     TIMEOUT);
            $display("Finished with errors");
            $finish;
        end
        @(negedge clk);
        chk.check_counts(exp_suc, exp_mis);
        if (num == 6)
            chk.check_first_pc(RESET_PC);
        tests_run++;
        if (total_errors() == errs_before) begin
            $display("Test %0d %s: passed", num, name);
        end else begin
            $display("Test %0d %s: failed", num, name);
            tests_failed++;
        end
        prog.delete();
    endtask

    initial begin
        logic [6:0] f7_tab [10];
        logic [2:0] f3_tab [10];
        int         k;
        f7_tab = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
        f3_tab = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        arst_n = 1'b0;
        void'($urandom(32'h66e4));

        // Dependent chain hits MEM, WB and write-through in turn
        prog.push_back(enc_u(rv_pkg::OP_LUI, 20'($urandom), 1));
        prog.push_back(enc_i(12'($urandom), 1, 3'd0, 1));
        prog.push_back(enc_u(rv_pkg::OP_LUI, 20'($urandom), 2));
        prog.push_back(enc_i(12'($urandom), 2, 3'd0, 2));
        for (int i = 0; i < 16; i++) begin
            k = $urandom % 10;
            prog.push_back(enc_r(f7_tab[k], (i % 2) ? i : i + 1, i + 2, f3_tab[k], i + 3));
        end
        prog.push_back(HALT);
        run_test(1, "R-type chains");

        prog.push_back(enc_i(12'($urandom), 0, 3'd0, 1));
        for (int f = 2; f < 8; f++) begin
            if (f != 5)
                prog.push_back(enc_i(12'($urandom), 1, 3'(f), f));
        end
        prog.push_back(enc_i({7'h00, 5'($urandom)}, 1, 3'd1, 8)); // slli
        prog.push_back(enc_i({7'h00, 5'($urandom)}, 1, 3'd5, 9)); // srli
        prog.push_back(enc_i({7'h20, 5'($urandom)}, 1, 3'd5, 10)); // srai
        prog.push_back(enc_i(12'd5, 1, 3'd0, 0));
        prog.push_back(enc_u(rv_pkg::OP_LUI, 20'($urandom), 11));
        prog.push_back(enc_u(rv_pkg::OP_LUI, 20'($urandom), 0));
        prog.push_back(enc_u(rv_pkg::OP_AUIPC, 20'($urandom), 12));
        prog.push_back(enc_u(rv_pkg::OP_AUIPC, 20'($urandom), 0));
        prog.push_back(enc_r(7'h00, 12, 11, 3'd0, 13));
        prog.push_back(HALT);
        run_test(2, "immediates, lui and auipc");

        prog.push_back(enc_i(12'd5, 0, 3'd0, 1));
        prog.push_back(enc_i(12'd0, 0, 3'd0, 2));
        prog.push_back(enc_r(7'h00, 1, 2, 3'd0, 2));
        prog.push_back(enc_i(12'hfff, 1, 3'd0, 1));
        prog.push_back(enc_b(13'h1ff8, 0, 1, rv_pkg::F3_BNE)); // Back to the add
        prog.push_back(enc_i(12'd1, 2, 3'd0, 3));
        prog.push_back(HALT);
        run_test(3, "backward branch loop");

        prog.push_back(enc_i(12'hffd, 0, 3'd0, 1)); // x1 = -3
        prog.push_back(enc_i(12'd5, 0, 3'd0, 2));
        prog.push_back(enc_b(13'd8, 1, 1, rv_pkg::F3_BEQ));
        prog.push_back(enc_i(12'd1, 0, 3'd0, 10)); // Wrong path
        prog.push_back(enc_i(12'd1, 0, 3'd0, 11));
        prog.push_back(enc_b(13'd8, 2, 1, rv_pkg::F3_BNE));
        prog.push_back(enc_i(12'd2, 0, 3'd0, 10));
        prog.push_back(enc_i(12'd2, 0, 3'd0, 12));
        prog.push_back(enc_b(13'd8, 2, 1, rv_pkg::F3_BLT));
        prog.push_back(enc_i(12'd3, 0, 3'd0, 10));
        prog.push_back(enc_i(12'd3, 0, 3'd0, 13));
        prog.push_back(enc_b(13'd8, 1, 2, rv_pkg::F3_BGE));
        prog.push_back(enc_i(12'd4, 0, 3'd0, 10));
        prog.push_back(enc_i(12'd4, 0, 3'd0, 14));
        prog.push_back(enc_b(13'd8, 1, 2, rv_pkg::F3_BLTU));
        prog.push_back(enc_i(12'd5, 0, 3'd0, 10));
        prog.push_back(enc_i(12'd5, 0, 3'd0, 15));
        prog.push_back(enc_b(13'd8, 2, 1, rv_pkg::F3_BGEU));
        prog.push_back(enc_i(12'd6, 0, 3'd0, 10));
        prog.push_back(enc_i(12'd6, 0, 3'd0, 16));
        prog.push_back(HALT);
        run_test(4, "forward taken branches");

        prog.push_back(enc_i(12'd7, 0, 3'd0, 1));
        prog.push_back(enc_j(21'd12, 5));
        prog.push_back(enc_i(12'd1, 0, 3'd0, 6));
        prog.push_back(enc_i(12'd2, 0, 3'd0, 6));
        prog.push_back(enc_r(7'h00, 1, 5, 3'd0, 7)); // Uses the link value
        prog.push_back(enc_j(21'd8, 8));
        prog.push_back(enc_i(12'd3, 0, 3'd0, 9));
        prog.push_back(enc_r(7'h00, 0, 8, 3'd0, 10));
        prog.push_back(HALT);
        run_test(5, "jal link");

        prog.push_back(enc_i(12'd1, 0, 3'd0, 1));
        prog.push_back(enc_i(12'd1, 1, 3'd0, 2));
        prog.push_back(HALT);
        run_test(6, "reset behavior");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- tests/wb_checker.sv
module wb_checker (
    input logic              clk,
    input logic              arst_n,
    input logic              wb_valid,
    input rv_pkg::word_t     wb_pc,
    input rv_pkg::reg_addr_t wb_rd,
    input rv_pkg::word_t     wb_data,
    input logic              br_suc,
    input logic              br_mispred
);

    int            errors = 0;
    int            suc_cnt = 0;
    int            mis_cnt = 0;
    logic          seen_wb = 1'b0;
    rv_pkg::word_t first_pc = '0;

    // Sampled mid-cycle, away from the DUT's clock edge
    always @(negedge clk) begin
        if (!arst_n) begin
            suc_cnt <= 0;
            mis_cnt <= 0;
            seen_wb <= 1'b0;
            if (wb_valid || br_suc || br_mispred) begin
                $display("Writeback or branch pulse seen while reset is asserted at %0t", $time);
                errors++;
            end
        end else begin
            if (br_suc)
                suc_cnt <= suc_cnt + 1;
            if (br_mispred)
                mis_cnt <= mis_cnt + 1;
            if (wb_valid) begin
                if (!seen_wb)
                    first_pc <= wb_pc;
                seen_wb <= 1'b1;
                if (tb_top.exp_pc.size() == 0) begin
                    $display("Unexpected extra writeback to x%0d from pc %h", wb_rd, wb_pc);
                    errors++;
                end else begin
                    compare_write(tb_top.exp_pc.pop_front(), tb_top.exp_rd.pop_front(),
                                  tb_top.exp_data.pop_front());
                end
            end
        end
    end

    task automatic compare_write(rv_pkg::word_t pc, rv_pkg::reg_addr_t rd, rv_pkg::word_t data);
        if (wb_pc !== pc || wb_rd !== rd || wb_data !== data) begin
            $display("Error at %0t: wb_pc %h (exp %h) wb_rd %0d (exp %0d) wb_data %h (exp %h)",
                     $time, wb_pc, pc, wb_rd, rd, wb_data, data);
            errors++;
        end
    endtask

    task automatic check_counts(int exp_suc, int exp_mis);
        if (suc_cnt != exp_suc || mis_cnt != exp_mis) begin
            $display("Branch counts differ: %0d correct and %0d mispredicted, expected %0d and %0d",
                     suc_cnt, mis_cnt, exp_suc, exp_mis);
            errors++;
        end
    endtask

    task automatic check_first_pc(rv_pkg::word_t pc);
        if (!seen_wb || first_pc !== pc) begin
            $display("Error at %0t: first wb_pc %h (exp %h)", $time, first_pc, pc);
            errors++;
        end
    endtask

endmodule
